//--- bench/lc3b_tb.sv
// ===================================================================
// lc3b pipeline testbench
// ===================================================================
`timescale 1ns/100ps

module lc3b_tb;

	localparam int imem_words = 256;
	localparam int random_commits = 200;	// commits past the directed part.
	localparam int cycles_per_commit = 40;
	localparam int reset_cycles = 16;

	logic clk;
	logic reset;
	logic imem_req;
	logic imem_ack;
	logic commit_valid;
	lc3b_types::lc3b_word imem_addr;
	lc3b_types::lc3b_word imem_rdata;
	lc3b_pipe::commit_t commit;

	lc3b_types::lc3b_word imem [imem_words];
	lc3b_types::lc3b_word model_pc;
	lc3b_types::lc3b_word model_regs [lc3b_types::num_regs];
	lc3b_types::lc3b_nzp model_cc;
	lc3b_types::lc3b_word model_mem [lc3b_types::dmem_words];
	int prog_len = 0;
	int directed_len = 0;
	int run_commits = 0;
	int checked = 0;
	int errors = 0;

	lc3b_pipe_top u_lc3b_pipe_top
	(
		.clk(clk),
		.reset(reset),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.imem_ack(imem_ack),
		.commit_valid(commit_valid),
		.commit(commit)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period.
	end

	function automatic lc3b_types::lc3b_word alu_word(input lc3b_types::lc3b_opcode op,
		input int dr, input int sr1, input logic imm_form, input int low5);
		return {op, dr[2:0], sr1[2:0], imm_form, low5[4:0]};
	endfunction

	function automatic lc3b_types::lc3b_word mem_word(input lc3b_types::lc3b_opcode op,
		input int r, input int base, input int off6);
		return {op, r[2:0], base[2:0], off6[5:0]};
	endfunction

	function automatic lc3b_types::lc3b_word br_word(input int nzp, input int off9);
		return {lc3b_types::op_br, nzp[2:0], off9[8:0]};
	endfunction

	// low bits of v, sign extended to a word.
	function automatic lc3b_types::lc3b_word sign_extend(input lc3b_types::lc3b_word v,
		input int bits);
		logic signed [15:0] s;
		s = v << (16 - bits);
		return s >>> (16 - bits);
	endfunction

	function automatic lc3b_types::lc3b_word random_instr();
		int kind;
		int r1;
		int r2;
		int r3;
		int imm;
		lc3b_types::lc3b_word w;
		kind = $urandom_range(5, 0);
		r1 = $urandom_range(7, 0);
		r2 = $urandom_range(7, 0);
		r3 = $urandom_range(7, 0);
		imm = $urandom_range(63, 0);
		case (kind)
			0: w = alu_word(lc3b_types::op_add, r1, r2, imm[5], imm[5] ? imm : r3);
			1: w = alu_word(lc3b_types::op_and, r1, r2, imm[5], imm[5] ? imm : r3);
			2: w = alu_word(lc3b_types::op_not, r1, r2, 1'b1, 31);
			3: w = mem_word(lc3b_types::op_ldr, r1, r2, imm);
			4: w = mem_word(lc3b_types::op_str, r1, r2, imm);
			default: w = br_word(r1, imm % 8);	// short forward hops only.
		endcase
		return w;
	endfunction

	task automatic put_instr(input lc3b_types::lc3b_word w);
		imem[prog_len] = w;
		prog_len = prog_len + 1;
	endtask

	task automatic build_program();
		put_instr(mem_word(lc3b_types::op_ldr, 1, 0, 5));	// memory was cleared.
		put_instr(16'hd123);	// unknown ops.
		put_instr(16'h3456);
		put_instr(alu_word(lc3b_types::op_add, 1, 0, 1'b1, 7));
		put_instr(alu_word(lc3b_types::op_add, 2, 1, 1'b1, -3));	// back to back.
		put_instr(alu_word(lc3b_types::op_add, 3, 1, 1'b0, 2));
		put_instr(alu_word(lc3b_types::op_and, 4, 3, 1'b1, 6));
		put_instr(alu_word(lc3b_types::op_and, 5, 3, 1'b0, 1));
		put_instr(alu_word(lc3b_types::op_not, 6, 5, 1'b1, 31));
		put_instr(alu_word(lc3b_types::op_add, 7, 6, 1'b0, 6));
		put_instr(mem_word(lc3b_types::op_str, 3, 1, 2));
		put_instr(mem_word(lc3b_types::op_ldr, 4, 1, 2));	// same address.
		put_instr(mem_word(lc3b_types::op_str, 6, 0, 9));
		put_instr(mem_word(lc3b_types::op_ldr, 5, 0, 9));
		put_instr(mem_word(lc3b_types::op_ldr, 2, 1, 3));	// untouched address.
		put_instr(alu_word(lc3b_types::op_add, 2, 2, 1'b0, 2));	// uses the load.
		// every mask against n, then z, then p.
		for (int cc_sel = 0; cc_sel < 3; cc_sel++)
		begin
			if (cc_sel == 0)
				put_instr(alu_word(lc3b_types::op_add, 1, 0, 1'b1, -1));
			else if (cc_sel == 1)
				put_instr(alu_word(lc3b_types::op_and, 1, 0, 1'b1, 0));
			else
				put_instr(alu_word(lc3b_types::op_add, 1, 0, 1'b1, 1));
			for (int mask = 0; mask < 8; mask++)
			begin
				put_instr(br_word(mask, 1));	// skips the store when taken.
				put_instr(mem_word(lc3b_types::op_str, mask, 0, 31));
			end
		end
		directed_len = prog_len;
		while (prog_len < imem_words)
			put_instr(random_instr());
		run_commits = directed_len + random_commits;
	endtask

	task automatic reset_model();
		model_pc = '0;
		model_cc = 3'b010;	// z.
		for (int i = 0; i < lc3b_types::num_regs; i++)
			model_regs[i] = '0;
		for (int i = 0; i < lc3b_types::dmem_words; i++)
			model_mem[i] = '0;
	endtask

	// one instruction on the model state, returns its commit.
	function automatic lc3b_pipe::commit_t model_step();
		lc3b_pipe::commit_t c;
		lc3b_types::lc3b_word ir;
		lc3b_types::lc3b_word src;
		lc3b_types::lc3b_word opnd;
		lc3b_types::lc3b_word addr;
		lc3b_types::lc3b_word res;
		logic writes;
		c = '0;
		ir = imem[model_pc[8:1]];
		src = model_regs[ir[8:6]];
		opnd = ir[5] ? sign_extend(ir, 5) : model_regs[ir[2:0]];
		addr = src + (sign_extend(ir, 6) << 1);
		res = '0;
		writes = 1'b1;
		c.pc = model_pc;
		c.opcode = lc3b_types::lc3b_opcode'(ir[15:12]);
		c.next_pc = model_pc + 16'd2;
		case (ir[15:12])
			lc3b_types::op_add: res = src + opnd;
			lc3b_types::op_and: res = src & opnd;
			lc3b_types::op_not: res = ~src;
			lc3b_types::op_ldr: res = model_mem[addr[8:1]];
			lc3b_types::op_str:
			begin
				writes = 1'b0;
				c.stored = 1'b1;
				c.store_addr = addr;
				c.store_data = model_regs[ir[11:9]];
				model_mem[addr[8:1]] = c.store_data;
			end
			lc3b_types::op_br:
			begin
				writes = 1'b0;
				c.taken = |(ir[11:9] & model_cc);
				if (c.taken)
					c.next_pc = model_pc + 16'd2 + (sign_extend(ir, 9) << 1);
			end
			default:
			begin
				writes = 1'b0;
				c.opcode = lc3b_types::op_br;	// shows up as opcode zero.
			end
		endcase
		if (writes)
		begin
			c.wrote = 1'b1;
			c.dest = ir[11:9];
			c.value = res;
			model_regs[ir[11:9]] = res;
			model_cc = {res[15], res == 16'd0, !res[15] && res != 16'd0};
		end
		model_pc = c.next_pc;
		return c;
	endfunction

	task automatic finish_run(input logic timed_out);
		$display("commits checked %0d of %0d, errors %0d", checked, run_commits, errors);
		if (errors == 0 && !timed_out)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	initial
	begin
		void'($urandom(32'h14ec_b2dc));
		reset = 1'b1;
		imem_ack = 1'b0;
		imem_rdata = '0;
		build_program();
		reset_model();
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		wait (run_commits != 0 && checked == run_commits);
		finish_run(1'b0);
	end

	// instruction memory side of the four-phase fetch port.
	initial
	begin : serve_fetch
		int delay;
		lc3b_types::lc3b_word addr;
		forever
		begin
			@(negedge clk);
			if (imem_req === 1'b1 && !imem_ack)
			begin
				addr = imem_addr;
				delay = $urandom_range(3, 0);
				repeat (delay) @(posedge clk);
				@(posedge clk);
				imem_rdata <= imem[addr[8:1]];
				imem_ack <= 1'b1;
				@(negedge clk);
				while (imem_req)
					@(negedge clk);	// wait for the core to let go.
				@(posedge clk);
				imem_ack <= 1'b0;
			end
		end
	end

	initial
	begin : compare_commits
		lc3b_pipe::commit_t expected;
		forever
		begin
			@(negedge clk);
			if (commit_valid === 1'b1)
			begin
				expected = model_step();
				assert (commit === expected)
				else
				begin
					errors++;
					$display("** Error @ %0d ns: commit %0d at pc %h, got %h, expected %h",
						$time, checked, expected.pc, commit, expected);
				end
				checked++;
			end
		end
	end

	initial
	begin : watchdog
		wait (run_commits != 0);
		repeat (reset_cycles + run_commits * cycles_per_commit) @(posedge clk);
		$display("watchdog expired, commits stopped after %0d of %0d", checked, run_commits);
		finish_run(1'b1);
	end

endmodule : lc3b_tb

//--- filelist.f
hw/lc3b_types.sv
hw/lc3b_pipe.sv
hw/control_rom.sv
hw/stage_reg.sv
hw/fetch_unit.sv
hw/regfile.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/lc3b_pipe_top.sv
bench/lc3b_tb.sv

//--- hw/control_rom.sv
// ===================================================================
// decode control rom
// ===================================================================
`timescale 1ns/100ps

module control_rom
(
	input lc3b_types::lc3b_opcode opcode,
	input logic ir5,
	output lc3b_pipe::lc3b_control_word ctrl
);

	always_comb
	begin
		ctrl = '0;	// everything off first.
		ctrl.opcode = opcode;
		ctrl.aluop = lc3b_types::alu_pass;
		ctrl.addr_sel = lc3b_pipe::addr_pc;
		ctrl.wbmux_sel = lc3b_pipe::wb_none;

		case (opcode)
			lc3b_types::op_add:
			begin
				ctrl.aluop = lc3b_types::alu_add;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.wbmux_sel = lc3b_pipe::wb_alu;
				ctrl.sr1_needed = 1'b1;
				ctrl.sr2_needed = !ir5;	// register form only.
				ctrl.sr2mux_sel = !ir5;
			end
			lc3b_types::op_and:
			begin
				ctrl.aluop = lc3b_types::alu_and;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.wbmux_sel = lc3b_pipe::wb_alu;
				ctrl.sr1_needed = 1'b1;
				ctrl.sr2_needed = !ir5;
				ctrl.sr2mux_sel = !ir5;
			end
			lc3b_types::op_not:
			begin
				ctrl.aluop = lc3b_types::alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.wbmux_sel = lc3b_pipe::wb_alu;
				ctrl.sr1_needed = 1'b1;
			end
			lc3b_types::op_ldr:
			begin
				ctrl.addr_sel = lc3b_pipe::addr_base;
				ctrl.lshf1 = 1'b1;	// word offset.
				ctrl.wbmux_sel = lc3b_pipe::wb_mem;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.dcache_enable = 1'b1;
				ctrl.sr1_needed = 1'b1;
			end
			lc3b_types::op_str:
			begin
				ctrl.addr_sel = lc3b_pipe::addr_base;
				ctrl.lshf1 = 1'b1;
				ctrl.dcache_enable = 1'b1;
				ctrl.dcacherw = 1'b1;
				ctrl.sr1_needed = 1'b1;
				ctrl.sr2_needed = 1'b1;	// store source in dr field.
			end
			lc3b_types::op_br:
			begin
				ctrl.addr_sel = lc3b_pipe::addr_pc;
				ctrl.lshf1 = 1'b1;
				ctrl.br_op = 1'b1;
				ctrl.br_stall = 1'b1;
			end
			default:
			begin
				ctrl = '0;	// unknown op, retires as nothing.
			end
		endcase
	end

endmodule : control_rom

//--- hw/decode_stage.sv
// ===================================================================
// decode stage
// ===================================================================
`timescale 1ns/100ps

module decode_stage
(
	input logic in_valid,
	input lc3b_pipe::fd_payload in_data,
	input logic ex_valid,
	input lc3b_types::lc3b_reg ex_dest,
	input logic ex_writes,
	output lc3b_types::lc3b_reg rf_raddr_a,
	output lc3b_types::lc3b_reg rf_raddr_b,
	input lc3b_types::lc3b_word rf_rdata_a,
	input lc3b_types::lc3b_word rf_rdata_b,
	output logic stall,
	output logic out_valid,
	output lc3b_pipe::de_payload out_data,
	output logic br_busy
);

	lc3b_pipe::lc3b_control_word ctrl;
	lc3b_types::lc3b_word ir;
	lc3b_types::lc3b_word imm;
	logic hazard_a;
	logic hazard_b;

	assign ir = in_data.instr;

	control_rom u_control_rom
	(
		.opcode(lc3b_types::lc3b_opcode'(ir[lc3b_types::op_lsb +: 4])),
		.ir5(ir[lc3b_types::imm_flag]),
		.ctrl(ctrl)
	);

	assign rf_raddr_a = ir[lc3b_types::sr1_lsb +: 3];
	// str reads its source from the dr field.
	assign rf_raddr_b = ctrl.dcacherw ? ir[lc3b_types::dr_lsb +: 3] : ir[lc3b_types::sr2_lsb +: 3];

	always_comb
	begin
		if (ctrl.br_op)
			imm = {{7{ir[8]}}, ir[8:0]};	// offset9.
		else if (ctrl.dcache_enable)
			imm = {{10{ir[5]}}, ir[5:0]};	// offset6.
		else
			imm = {{11{ir[4]}}, ir[4:0]};	// imm5.
	end

	// only execute needs a check, write-back forwards in the regfile.
	assign hazard_a = ctrl.sr1_needed && (rf_raddr_a == ex_dest);
	assign hazard_b = ctrl.sr2_needed && (rf_raddr_b == ex_dest);
	assign stall = in_valid && ex_valid && ex_writes && (hazard_a || hazard_b);
	assign out_valid = in_valid && !stall;	// bubble on stall.
	assign br_busy = in_valid && ctrl.br_stall;

	always_comb
	begin
		out_data.ctrl = ctrl;
		out_data.pc = in_data.pc;
		out_data.sr1 = rf_rdata_a;
		out_data.sr2 = rf_rdata_b;
		out_data.imm = imm;
		out_data.dest = ir[lc3b_types::dr_lsb +: 3];
		out_data.nzp = ir[lc3b_types::dr_lsb +: 3];	// br mask shares the field.
	end

endmodule : decode_stage

//--- hw/execute_stage.sv
// ===================================================================
// execute stage
// ===================================================================
`timescale 1ns/100ps

module execute_stage
(
	input logic in_valid,
	input lc3b_pipe::de_payload in_data,
	output lc3b_types::lc3b_reg ex_dest,
	output logic ex_writes,
	output logic out_valid,
	output lc3b_pipe::em_payload out_data
);

	lc3b_types::lc3b_word alu_b;
	lc3b_types::lc3b_word alu_out;
	lc3b_types::lc3b_word offset;
	lc3b_types::lc3b_word base;
	lc3b_types::lc3b_word addr;

	assign alu_b = in_data.ctrl.sr2mux_sel ? in_data.sr2 : in_data.imm;

	always_comb
	begin
		case (in_data.ctrl.aluop)
			lc3b_types::alu_add: alu_out = in_data.sr1 + alu_b;
			lc3b_types::alu_and: alu_out = in_data.sr1 & alu_b;
			lc3b_types::alu_not: alu_out = ~in_data.sr1;
			lc3b_types::alu_pass: alu_out = alu_b;
		endcase
	end

	// address adder, base register or pc + 2.
	assign offset = in_data.ctrl.lshf1 ? {in_data.imm[14:0], 1'b0} : in_data.imm;
	assign base = (in_data.ctrl.addr_sel == lc3b_pipe::addr_base) ? in_data.sr1 :
		in_data.pc + 16'd2;
	assign addr = base + offset;

	assign ex_dest = in_data.dest;	// for the decode interlock.
	assign ex_writes = in_data.ctrl.load_regfile;
	assign out_valid = in_valid;

	always_comb
	begin
		out_data.ctrl = in_data.ctrl;
		out_data.pc = in_data.pc;
		if (in_data.ctrl.dcache_enable || in_data.ctrl.br_op)
			out_data.result = addr;	// memory address or branch target.
		else
			out_data.result = alu_out;
		out_data.store_data = in_data.sr2;
		out_data.dest = in_data.dest;
		out_data.nzp = in_data.nzp;
	end

endmodule : execute_stage

//--- hw/fetch_unit.sv
// ===================================================================
// fetch unit
// ===================================================================
`timescale 1ns/100ps

module fetch_unit
(
	input logic clk,
	input logic reset,
	input logic hold,
	input logic branch_pending,
	input logic redirect_valid,
	input lc3b_types::lc3b_word redirect_pc,
	output logic imem_req,
	output lc3b_types::lc3b_word imem_addr,
	input lc3b_types::lc3b_word imem_rdata,
	input logic imem_ack,
	output logic out_valid,
	output lc3b_pipe::fd_payload out_data
);

	typedef enum logic [1:0] {s_idle, s_req, s_release} fetch_state_t;

	fetch_state_t state;
	lc3b_types::lc3b_word pc;
	logic capture;

	// data is taken only when decode can accept it.
	assign capture = (state == s_req) && imem_ack && !hold;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= s_idle;
			pc <= '0;
		end
		else
		begin
			case (state)
				s_idle:
					if (!hold && !branch_pending && !redirect_valid)
						state <= s_req;	// raise req next.
				s_req:
					if (capture)
						state <= s_release;	// drop req.
				s_release:
					if (!imem_ack)
						state <= s_idle;	// ack gone, cycle done.
				default:
					state <= s_idle;
			endcase
			if (redirect_valid)
				pc <= redirect_pc;	// branch resolved.
			else if (capture)
				pc <= pc + 16'd2;
		end
	end

	assign imem_req = (state == s_req);
	assign imem_addr = pc;	// stable through the request.
	assign out_valid = capture;
	assign out_data.pc = pc;
	assign out_data.instr = imem_rdata;

endmodule : fetch_unit

//--- hw/lc3b_pipe.sv
// ===================================================================
// pipeline payload types
// ===================================================================
package lc3b_pipe;

	localparam logic [1:0] wb_none = 2'b00;	// no write-back.
	localparam logic [1:0] wb_mem = 2'b01;	// load data.
	localparam logic [1:0] wb_alu = 2'b11;	// alu result.
	localparam logic addr_pc = 1'b0;	// pc + 2 as base.
	localparam logic addr_base = 1'b1;	// sr1 as base.

	typedef struct packed
	{
		lc3b_types::lc3b_opcode opcode;
		lc3b_types::lc3b_aluop aluop;
		logic sr1_needed;
		logic sr2_needed;	// also the str source.
		logic sr2mux_sel;	// 1 picks sr2, 0 picks imm.
		logic addr_sel;
		logic br_op;
		logic br_stall;	// holds fetch.
		logic lshf1;
		logic [1:0] wbmux_sel;
		logic load_regfile;
		logic load_cc;
		logic dcache_enable;
		logic dcacherw;	// 1 is a store.
	} lc3b_control_word;

	typedef struct packed
	{
		lc3b_types::lc3b_word pc;
		lc3b_types::lc3b_word instr;
	} fd_payload;

	typedef struct packed
	{
		lc3b_control_word ctrl;
		lc3b_types::lc3b_word pc;
		lc3b_types::lc3b_word sr1;
		lc3b_types::lc3b_word sr2;	// or store value.
		lc3b_types::lc3b_word imm;	// already sign extended.
		lc3b_types::lc3b_reg dest;
		lc3b_types::lc3b_nzp nzp;
	} de_payload;

	typedef struct packed
	{
		lc3b_control_word ctrl;
		lc3b_types::lc3b_word pc;
		lc3b_types::lc3b_word result;	// alu value or address.
		lc3b_types::lc3b_word store_data;
		lc3b_types::lc3b_reg dest;
		lc3b_types::lc3b_nzp nzp;
	} em_payload;

	typedef struct packed
	{
		lc3b_types::lc3b_word pc;
		lc3b_types::lc3b_opcode opcode;
		logic wrote;
		lc3b_types::lc3b_reg dest;
		lc3b_types::lc3b_word value;
		logic stored;
		lc3b_types::lc3b_word store_addr;
		lc3b_types::lc3b_word store_data;
		logic taken;
		lc3b_types::lc3b_word next_pc;
	} commit_t;

endpackage

//--- hw/lc3b_pipe_top.sv
// ===================================================================
// lc3b pipeline top
// ===================================================================
`timescale 1ns/100ps

module lc3b_pipe_top
(
	input logic clk,
	input logic reset,
	output logic imem_req,
	output lc3b_types::lc3b_word imem_addr,
	input lc3b_types::lc3b_word imem_rdata,
	input logic imem_ack,
	output logic commit_valid,
	output lc3b_pipe::commit_t commit
);

	lc3b_pipe::fd_payload fetch_data, fd_data;
	lc3b_pipe::de_payload dec_data, de_data;
	lc3b_pipe::em_payload ex_data, em_data;
	logic fetch_valid, fd_valid, dec_valid, de_valid, ex_valid_o, em_valid;
	logic dec_stall, dec_br_busy, wb_br_busy, branch_pending;
	logic ex_writes, redirect_valid, rf_we;
	lc3b_types::lc3b_reg ex_dest, rf_raddr_a, rf_raddr_b, rf_waddr;
	lc3b_types::lc3b_word rf_rdata_a, rf_rdata_b, rf_wdata, redirect_pc;

	// decode, execute or write-back.
	assign branch_pending = dec_br_busy | (de_valid & de_data.ctrl.br_stall) | wb_br_busy;

	fetch_unit u_fetch_unit (.clk(clk), .reset(reset), .hold(dec_stall),
		.branch_pending(branch_pending), .redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc), .imem_req(imem_req), .imem_addr(imem_addr),
		.imem_rdata(imem_rdata), .imem_ack(imem_ack), .out_valid(fetch_valid),
		.out_data(fetch_data));

	stage_reg #(.payload_t(lc3b_pipe::fd_payload)) u_fd_reg (.clk(clk), .reset(reset),
		.stall(dec_stall), .flush(reset), .in_valid(fetch_valid), .in_data(fetch_data),
		.out_valid(fd_valid), .out_data(fd_data));

	decode_stage u_decode_stage (.in_valid(fd_valid), .in_data(fd_data),
		.ex_valid(de_valid), .ex_dest(ex_dest), .ex_writes(ex_writes),
		.rf_raddr_a(rf_raddr_a), .rf_raddr_b(rf_raddr_b), .rf_rdata_a(rf_rdata_a),
		.rf_rdata_b(rf_rdata_b), .stall(dec_stall), .out_valid(dec_valid),
		.out_data(dec_data), .br_busy(dec_br_busy));

	stage_reg #(.payload_t(lc3b_pipe::de_payload)) u_de_reg (.clk(clk), .reset(reset),
		.stall(1'b0), .flush(reset), .in_valid(dec_valid), .in_data(dec_data),
		.out_valid(de_valid), .out_data(de_data));

	execute_stage u_execute_stage (.in_valid(de_valid), .in_data(de_data),
		.ex_dest(ex_dest), .ex_writes(ex_writes), .out_valid(ex_valid_o),
		.out_data(ex_data));

	stage_reg #(.payload_t(lc3b_pipe::em_payload)) u_em_reg (.clk(clk), .reset(reset),
		.stall(1'b0), .flush(reset), .in_valid(ex_valid_o), .in_data(ex_data),
		.out_valid(em_valid), .out_data(em_data));

	mem_wb_stage u_mem_wb_stage (.clk(clk), .reset(reset), .in_valid(em_valid),
		.in_data(em_data), .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.br_busy(wb_br_busy), .commit_valid(commit_valid), .commit(commit));

	regfile u_regfile (.clk(clk), .reset(reset), .we(rf_we), .waddr(rf_waddr),
		.wdata(rf_wdata), .raddr_a(rf_raddr_a), .raddr_b(rf_raddr_b),
		.rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b));

endmodule : lc3b_pipe_top

//--- hw/lc3b_types.sv
// ===================================================================
// lc3b isa types
// ===================================================================
package lc3b_types;

	typedef logic [15:0] lc3b_word;	// data or byte address.
	typedef logic [2:0] lc3b_reg;	// register index.
	typedef logic [2:0] lc3b_nzp;	// n, z, p flags.

	typedef enum logic [3:0]
	{
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0]
	{
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_aluop;

	localparam int num_regs = 8;
	localparam int dmem_words = 256;
	localparam int dmem_aw = $clog2(dmem_words);	// word index width.

	localparam int op_lsb = 12;	// opcode, 4 bits.
	localparam int dr_lsb = 9;	// dest or nzp, 3 bits.
	localparam int sr1_lsb = 6;	// base or sr1, 3 bits.
	localparam int sr2_lsb = 0;	// sr2, 3 bits.
	localparam int imm_flag = 5;	// ir5.

endpackage

//--- hw/mem_wb_stage.sv
// ===================================================================
// memory and write-back stage
// ===================================================================
`timescale 1ns/100ps

module mem_wb_stage
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input lc3b_pipe::em_payload in_data,
	output logic rf_we,
	output lc3b_types::lc3b_reg rf_waddr,
	output lc3b_types::lc3b_word rf_wdata,
	output logic redirect_valid,
	output lc3b_types::lc3b_word redirect_pc,
	output logic br_busy,
	output logic commit_valid,
	output lc3b_pipe::commit_t commit
);

	lc3b_types::lc3b_word dmem [lc3b_types::dmem_words];
	lc3b_types::lc3b_nzp cc;
	logic [lc3b_types::dmem_aw-1:0] idx;
	lc3b_types::lc3b_word wb_value;
	lc3b_types::lc3b_word next_pc;
	logic store;
	logic taken;

	assign idx = in_data.result[lc3b_types::dmem_aw:1];	// word index.
	assign store = in_valid && in_data.ctrl.dcache_enable && in_data.ctrl.dcacherw;

	always_comb
	begin
		case (in_data.ctrl.wbmux_sel)
			lc3b_pipe::wb_mem: wb_value = dmem[idx];
			lc3b_pipe::wb_alu: wb_value = in_data.result;
			default: wb_value = '0;
		endcase
	end

	assign rf_we = in_valid && in_data.ctrl.load_regfile;
	assign rf_waddr = in_data.dest;
	assign rf_wdata = wb_value;
	// cc here is already committed by every older instruction.
	assign taken = in_valid && in_data.ctrl.br_op && |(in_data.nzp & cc);
	assign next_pc = taken ? in_data.result : in_data.pc + 16'd2;
	assign br_busy = in_valid && in_data.ctrl.br_stall;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < lc3b_types::dmem_words; i++)
				dmem[i] <= '0;
		end
		else if (store)
			dmem[idx] <= in_data.store_data;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cc <= 3'b010;	// z after reset.
			redirect_valid <= 1'b0;
			commit_valid <= 1'b0;
		end
		else
		begin
			if (in_valid && in_data.ctrl.load_cc)
				cc <= {wb_value[15], wb_value == '0, !wb_value[15] && wb_value != '0};
			redirect_valid <= in_valid && in_data.ctrl.br_op;	// taken or not.
			commit_valid <= in_valid;
		end
	end

	// unknown opcodes report opcode zero.
	always_ff @(posedge clk)
	begin
		redirect_pc <= next_pc;
		commit.pc <= in_data.pc;
		commit.opcode <= in_data.ctrl.opcode;
		commit.wrote <= rf_we;
		commit.dest <= rf_we ? in_data.dest : '0;
		commit.value <= rf_we ? wb_value : '0;
		commit.stored <= store;
		commit.store_addr <= store ? in_data.result : '0;
		commit.store_data <= store ? in_data.store_data : '0;
		commit.taken <= taken;
		commit.next_pc <= next_pc;
	end

endmodule : mem_wb_stage

//--- hw/regfile.sv
// ===================================================================
// register file
// ===================================================================
`timescale 1ns/100ps

module regfile
(
	input logic clk,
	input logic reset,
	input logic we,
	input lc3b_types::lc3b_reg waddr,
	input lc3b_types::lc3b_word wdata,
	input lc3b_types::lc3b_reg raddr_a,
	input lc3b_types::lc3b_reg raddr_b,
	output lc3b_types::lc3b_word rdata_a,
	output lc3b_types::lc3b_word rdata_b
);

	lc3b_types::lc3b_word regs [lc3b_types::num_regs];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < lc3b_types::num_regs; i++)
				regs[i] <= '0;	// all registers start at zero.
		end
		else if (we)
			regs[waddr] <= wdata;
	end

	// same cycle write goes straight to the readers.
	assign rdata_a = (we && waddr == raddr_a) ? wdata : regs[raddr_a];
	assign rdata_b = (we && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule : regfile

//--- hw/stage_reg.sv
// ===================================================================
// pipeline stage register
// ===================================================================
`timescale 1ns/100ps

module stage_reg
#(
	parameter type payload_t = logic
)
(
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input logic in_valid,
	input payload_t in_data,
	output logic out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			out_valid <= 1'b0;	// flush beats stall.
		else if (!stall)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
			out_data <= in_data;	// payload follows valid.
	end

endmodule : stage_reg

//--- run_sim.sh
#!/bin/sh
# builds and runs the lc3b pipeline testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f filelist.f --top-module lc3b_tb \
	-Mdir "$build_dir" -o lc3b_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"./$build_dir/lc3b_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Regression failed" "$log_file"; then
	exit 1
fi
exit 0
